// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/cpu_ctrl_if.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

interface cpu_ctrl_if import cpu_pkg::*; ();

    logic load_origin;                  // PC <= origin
    logic load_mar_pc;
    logic load_mar_temp;                // MAR <= {temp_2, temp_1}
    logic oe_ram;
    logic we_ram;
    logic pc_enable;                    // PC increment
    logic load_pc;                      // Jump
    logic load_ir;
    logic load_temp_1;
    logic load_temp_2;
    logic oe_temp_1;
    logic oe_a;
    logic oe_alu;
    logic alu_sub;
    logic load_a;
    logic load_flags;
    logic load_out;
    opcode_t    opcode;                 // IR contents back to the sequencer
    logic [2:0] flags;                  // N, C, Z

    modport control (
        output load_origin, load_mar_pc, load_mar_temp, oe_ram, we_ram, pc_enable, load_pc,
               load_ir, load_temp_1, load_temp_2, oe_temp_1, oe_a, oe_alu, alu_sub,
               load_a, load_flags, load_out,
        input  opcode, flags
    );

    modport datapath (
        input  load_origin, load_mar_pc, load_mar_temp, oe_ram, we_ram, pc_enable, load_pc,
               load_ir, load_temp_1, load_temp_2, oe_temp_1, oe_a, oe_alu, alu_sub,
               load_a, load_flags, load_out,
        output opcode, flags
    );

endinterface

// ==== common/cpu_mem_if.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

interface cpu_mem_if import cpu_pkg::*; ();

    addr_t addr;                        // From the MAR
    data_t wdata;                       // Bus value for STA
    logic  we;
    data_t rdata;                       // Async read of addr

    modport cpu (
        output addr, wdata, we,
        input  rdata
    );

    modport ram (
        input  addr, wdata, we,
        output rdata
    );

endinterface

// ==== common/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] data_t;        // One byte
    typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;        // Full address

    // Bit positions inside the flags vector
    localparam int FLAG_Z = 0;                          // Zero
    localparam int FLAG_C = 1;                          // Carry or borrow
    localparam int FLAG_N = 2;                          // Negative

    typedef enum logic [7:0] {
        NOP   = 8'h00,
        HLT   = 8'h01,
        LDI_A = 8'h0C,                                  // A <= imm
        LDA   = 8'h0D,                                  // A <= mem[addr]
        STA   = 8'h0E,                                  // mem[addr] <= A
        ADI   = 8'h10,
        SBI   = 8'h11,
        OUT   = 8'h20,
        JMP   = 8'h30,
        JZ    = 8'h31,
        JC    = 8'h32,
        JN    = 8'h33
    } opcode_t;

    typedef enum logic [2:0] {
        S_RESET,                                        // Idle until start
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } fsm_state_t;

    typedef enum logic [$clog2(`CPU_MICROSTEPS)-1:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    // One microcode word; the first 17 fields reach the datapath
    typedef struct packed {
        logic load_origin;
        logic load_mar_pc;
        logic load_mar_temp;
        logic oe_ram;
        logic we_ram;
        logic pc_enable;
        logic load_pc;
        logic load_ir;
        logic load_temp_1;
        logic load_temp_2;
        logic oe_temp_1;
        logic oe_a;
        logic oe_alu;
        logic alu_sub;
        logic load_a;
        logic load_flags;
        logic load_out;
        logic check_zero;                               // Sequencer only from here on
        logic check_carry;
        logic check_negative;
        logic halt;
        logic last_step;
    } control_word_t;

endpackage

// ==== common/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath widths
`define CPU_DATA_WIDTH 8            // Byte and bus width
`define CPU_ADDR_WIDTH 16           // PC, MAR and jump target width

// Memory
`define CPU_RAM_DEPTH 1024          // Bytes actually decoded by the RAM

// Microcode
`define CPU_MICROSTEPS 8            // Steps available per opcode

// Program origin loaded into the PC on start
`define CPU_ORIGIN 16'h0000

`endif

// ==== control/control_unit.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module control_unit import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    cpu_ctrl_if.control ctrl,
    output logic        halted
);

    fsm_state_t    state, next_state;
    microstep_t    microstep, next_microstep;
    logic [1:0]    byte_count, next_byte_count;   // Bytes of current instruction fetched
    logic [1:0]    num_operand_bytes;
    logic          op_unknown;
    control_word_t rom_word;                      // ROM output for opcode/step
    control_word_t cw;                            // Word actually driven
    logic          check_active;
    logic          check_pass;

    // =========================================================================
    // Operand count decode
    always_comb begin
        op_unknown = 1'b0;
        case (ctrl.opcode)
            NOP, HLT, OUT:              num_operand_bytes = 2'd0;
            LDI_A, ADI, SBI:            num_operand_bytes = 2'd1;   // Immediate
            LDA, STA, JMP, JZ, JC, JN:  num_operand_bytes = 2'd2;   // lo, hi
            default: begin
                num_operand_bytes = 2'd0;
                op_unknown        = 1'b1;                          // Halts in CHK
            end
        endcase
    end

    // =========================================================================
    // Microcode ROM indexed by opcode and microstep
    always_comb begin
        rom_word = '{default: 1'b0, halt: 1'b1};  // Unused slots stop the CPU
        case (ctrl.opcode)
            NOP: rom_word = '{default: 1'b0, last_step: 1'b1};
            HLT: rom_word = '{default: 1'b0, halt: 1'b1};
            OUT: rom_word = '{default: 1'b0, oe_a: 1'b1, load_out: 1'b1, last_step: 1'b1};
            LDI_A: case (microstep)
                MS0: rom_word = '{default: 1'b0, oe_temp_1: 1'b1};
                MS1: rom_word = '{default: 1'b0, oe_temp_1: 1'b1, load_a: 1'b1,
                                  load_flags: 1'b1, last_step: 1'b1};
                default: ;
            endcase
            ADI, SBI: case (microstep)
                MS0: rom_word = '{default: 1'b0, oe_alu: 1'b1, alu_sub: (ctrl.opcode == SBI)};
                MS1: rom_word = '{default: 1'b0, oe_alu: 1'b1, alu_sub: (ctrl.opcode == SBI),
                                  load_a: 1'b1, load_flags: 1'b1, last_step: 1'b1};
                default: ;
            endcase
            LDA: case (microstep)
                MS0: rom_word = '{default: 1'b0, load_mar_temp: 1'b1};
                MS1: rom_word = '{default: 1'b0, oe_ram: 1'b1};          // Read settles
                MS2: rom_word = '{default: 1'b0, oe_ram: 1'b1, load_a: 1'b1,
                                  load_flags: 1'b1, last_step: 1'b1};
                default: ;
            endcase
            STA: case (microstep)
                MS0: rom_word = '{default: 1'b0, load_mar_temp: 1'b1};
                MS1: rom_word = '{default: 1'b0, oe_a: 1'b1};
                MS2: rom_word = '{default: 1'b0, oe_a: 1'b1, we_ram: 1'b1, last_step: 1'b1};
                default: ;
            endcase
            JMP, JZ, JC, JN: case (microstep)
                MS0: rom_word = '{default: 1'b0,
                                  check_zero:     (ctrl.opcode == JZ),
                                  check_carry:    (ctrl.opcode == JC),
                                  check_negative: (ctrl.opcode == JN)};
                MS1: rom_word = '{default: 1'b0};                        // Target settles
                MS2: rom_word = '{default: 1'b0, load_pc: 1'b1, last_step: 1'b1};
                default: ;
            endcase
            default: ;
        endcase
    end

    assign check_active = rom_word.check_zero | rom_word.check_carry | rom_word.check_negative;
    assign check_pass   = (rom_word.check_zero     & ctrl.flags[FLAG_Z])
                        | (rom_word.check_carry    & ctrl.flags[FLAG_C])
                        | (rom_word.check_negative & ctrl.flags[FLAG_N]);

    // =========================================================================
    // Sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            microstep  <= MS0;
            byte_count <= 2'd0;
        end else begin
            state      <= next_state;
            microstep  <= next_microstep;
            byte_count <= next_byte_count;
        end
    end

    always_comb begin
        next_state      = state;
        next_microstep  = microstep;
        next_byte_count = byte_count;
        cw              = '{default: 1'b0};
        case (state)
            S_RESET: if (start) next_state = S_INIT;
            S_INIT: begin
                cw.load_origin = 1'b1;
                next_state     = S_LATCH_ADDR;
            end
            S_LATCH_ADDR: begin
                cw.load_mar_pc = 1'b1;
                next_state     = S_READ_BYTE;
            end
            S_READ_BYTE: begin
                cw.oe_ram  = 1'b1;                        // Async RAM settles
                next_state = S_LATCH_BYTE;
            end
            S_LATCH_BYTE: begin
                cw.oe_ram       = 1'b1;
                cw.pc_enable    = 1'b1;
                cw.load_ir      = (byte_count == 2'd0);
                cw.load_temp_1  = (byte_count == 2'd1);
                cw.load_temp_2  = (byte_count == 2'd2);
                next_byte_count = byte_count + 2'd1;
                next_state      = S_CHK_MORE_BYTES;
            end
            S_CHK_MORE_BYTES: begin
                if (op_unknown) begin
                    next_state = S_HALT;
                end else if (byte_count > num_operand_bytes) begin
                    next_state      = S_EXECUTE;
                    next_byte_count = 2'd0;
                end else begin
                    next_state = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                cw = rom_word;
                if (rom_word.halt) begin
                    next_state     = S_HALT;
                    next_microstep = MS0;
                end else if (check_active && !check_pass) begin
                    cw.load_pc     = 1'b0;                // Branch not taken
                    next_state     = S_LATCH_ADDR;
                    next_microstep = MS0;
                end else if (rom_word.last_step) begin
                    next_state     = S_LATCH_ADDR;
                    next_microstep = MS0;
                end else begin
                    next_microstep = microstep_t'(microstep + 1'b1);
                end
            end
            S_HALT: next_state = S_HALT;
            default: next_state = S_HALT;
        endcase
    end

    assign halted = (state == S_HALT);

    // Strobes to the datapath
    assign ctrl.load_origin   = cw.load_origin;
    assign ctrl.load_mar_pc   = cw.load_mar_pc;
    assign ctrl.load_mar_temp = cw.load_mar_temp;
    assign ctrl.oe_ram        = cw.oe_ram;
    assign ctrl.we_ram        = cw.we_ram;
    assign ctrl.pc_enable     = cw.pc_enable;
    assign ctrl.load_pc       = cw.load_pc;
    assign ctrl.load_ir       = cw.load_ir;
    assign ctrl.load_temp_1   = cw.load_temp_1;
    assign ctrl.load_temp_2   = cw.load_temp_2;
    assign ctrl.oe_temp_1     = cw.oe_temp_1;
    assign ctrl.oe_a          = cw.oe_a;
    assign ctrl.oe_alu        = cw.oe_alu;
    assign ctrl.alu_sub       = cw.alu_sub;
    assign ctrl.load_a        = cw.load_a;
    assign ctrl.load_flags    = cw.load_flags;
    assign ctrl.load_out      = cw.load_out;

    // =========================================================================
    // Checks
    a_bus_single_driver: assert property (@(posedge clk) disable iff (reset)
        $onehot0({cw.oe_ram, cw.oe_temp_1, cw.oe_a, cw.oe_alu}))
        else $error("Bus contention in state %s", state.name());

    a_halted_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else $error("halted dropped without reset");

    // Longest opcode uses MS0 to MS2
    a_microstep_range: assert property (@(posedge clk) disable iff (reset)
        (state == S_EXECUTE) |-> (microstep <= MS2))
        else $error("Microstep %0d past the last microcode step", microstep);

endmodule

// ==== cpu.f ====
+incdir+common
common/cpu_pkg.sv
common/cpu_ctrl_if.sv
common/cpu_mem_if.sv
control/control_unit.sv
src/datapath.sv
src/program_ram.sv
src/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,                   // Begin at origin
    input  logic  prog_we,
    input  addr_t prog_addr,
    input  data_t prog_data,
    output data_t out_data,
    output logic  out_valid,               // Pulse per OUT
    output logic  halted                   // Level until reset
);

    cpu_ctrl_if ctrl_bus ();
    cpu_mem_if  mem_bus ();

    // Sequencer and microcode
    control_unit control_unit_inst (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .ctrl   (ctrl_bus.control),
        .halted (halted)
    );

    // Registers, ALU and bus
    datapath datapath_inst (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl_bus.datapath),
        .mem       (mem_bus.cpu),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    // Program and data store
    program_ram program_ram_inst (
        .clk       (clk),
        .mem       (mem_bus.ram),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

endmodule

// ==== src/datapath.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module datapath import cpu_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    cpu_ctrl_if.datapath ctrl,
    cpu_mem_if.cpu       mem,
    output data_t        out_data,
    output logic         out_valid
);

    addr_t      pc;
    addr_t      mar;
    addr_t      temp_addr;                  // {hi, lo} operand pair
    data_t      ir;
    data_t      temp_1;                     // Immediate or address low byte
    data_t      temp_2;                     // Address high byte
    data_t      a_reg;
    data_t      out_reg;
    data_t      bus;
    data_t      alu_result;
    logic       alu_carry;
    logic [`CPU_DATA_WIDTH:0] alu_full;     // Extra bit holds carry/borrow
    logic [2:0] flags;

    assign temp_addr = {temp_2, temp_1};

    // =========================================================================
    // Bus and ALU
    always_comb begin
        if (ctrl.oe_ram)         bus = mem.rdata;
        else if (ctrl.oe_temp_1) bus = temp_1;
        else if (ctrl.oe_a)      bus = a_reg;
        else if (ctrl.oe_alu)    bus = alu_result;
        else                     bus = '0;      // Idle bus
    end

    always_comb begin
        if (ctrl.alu_sub)
            alu_full = {1'b0, a_reg} - {1'b0, temp_1};    // Top bit set on borrow
        else
            alu_full = {1'b0, a_reg} + {1'b0, temp_1};
    end

    assign alu_result = alu_full[`CPU_DATA_WIDTH-1:0];
    assign alu_carry  = alu_full[`CPU_DATA_WIDTH];

    // =========================================================================
    // Control registers
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            ir        <= '0;                    // Reads as NOP
            flags     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (ctrl.load_origin)    pc <= `CPU_ORIGIN;
            else if (ctrl.load_pc)   pc <= temp_addr;
            else if (ctrl.pc_enable) pc <= pc + 1'b1;
            if (ctrl.load_ir)        ir <= bus;
            if (ctrl.load_flags) begin
                flags[FLAG_Z] <= (bus == '0);
                flags[FLAG_N] <= bus[`CPU_DATA_WIDTH-1];
                flags[FLAG_C] <= ctrl.oe_alu & alu_carry;  // Loads clear carry
            end
            out_valid <= ctrl.load_out;         // One-cycle pulse
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (ctrl.load_mar_pc)   mar <= pc;
        if (ctrl.load_mar_temp) mar <= temp_addr;
        if (ctrl.load_temp_1)   temp_1 <= bus;
        if (ctrl.load_temp_2)   temp_2 <= bus;
        if (ctrl.load_a)        a_reg <= bus;
        if (ctrl.load_out)      out_reg <= bus;
    end

    // =========================================================================
    // Outputs
    assign mem.addr    = mar;
    assign mem.wdata   = bus;
    assign mem.we      = ctrl.we_ram;
    assign ctrl.opcode = opcode_t'(ir);
    assign ctrl.flags  = flags;
    assign out_data    = out_reg;

    a_mar_one_source: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.load_mar_pc && ctrl.load_mar_temp))
        else $error("MAR loaded from PC and temp together");

endmodule

// ==== src/program_ram.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module program_ram import cpu_pkg::*; (
    input  logic   clk,
    cpu_mem_if.ram mem,
    input  logic   prog_we,                 // Load port strobe
    input  addr_t  prog_addr,
    input  data_t  prog_data
);

    localparam int RAM_AW = $clog2(`CPU_RAM_DEPTH);     // Decoded address bits

    data_t mem_array [`CPU_RAM_DEPTH];
    logic [RAM_AW-1:0] cpu_index;
    logic [RAM_AW-1:0] load_index;

    assign cpu_index  = mem.addr[RAM_AW-1:0];      // Upper bits alias
    assign load_index = prog_addr[RAM_AW-1:0];

    // Load port has priority on a shared cycle
    always_ff @(posedge clk) begin
        if (prog_we)
            mem_array[load_index] <= prog_data;
        else if (mem.we)
            mem_array[cpu_index] <= mem.wdata;
    end

    // Async read from the registered MAR
    assign mem.rdata = mem_array[cpu_index];

endmodule

// ==== verif/cpu_checker.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_checker import cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  out_valid,
    input  data_t out_data,
    input  logic  halted,
    output int    mismatch_count,
    output int    unexpected_count,
    output int    checked_count
);

    data_t expected_q [$];                        // Filled by the ISA model before start
    data_t expected;
    int    mismatches = 0;
    int    unexpected = 0;
    int    checked    = 0;

    assign mismatch_count   = mismatches;
    assign unexpected_count = unexpected;
    assign checked_count    = checked;

    // ========================================================================
    // Queue access for the testbench
    task automatic push_expected(input data_t value);
        expected_q.push_back(value);
    endtask

    function automatic int pending_count();
        return expected_q.size();
    endfunction

    task automatic flush_expected();
        expected_q.delete();                      // Drop leftovers of a failed program
    endtask

    // ========================================================================
    // Output compare sampled mid-cycle where out_data is stable
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (halted) begin
                $display("Output 0x%02h at %0t came after the CPU halted", out_data, $time);
                unexpected++;
            end else if (expected_q.size() == 0) begin
                $display("Output 0x%02h at %0t had no expected value left", out_data, $time);
                unexpected++;
            end else begin
                expected = expected_q.pop_front();
                checked++;
                if (out_data !== expected) begin
                    $display("ERR @%0t: out_data 0x%02h, expected 0x%02h",
                             $time, out_data, expected);
                    mismatches++;
                end
            end
        end
    end

endmodule

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_PROGRAMS   = 40;
    localparam int MIN_INSTR      = 8;
    localparam int MAX_INSTR      = 64;
    localparam int RAM_WORDS      = `CPU_RAM_DEPTH;
    localparam int RAM_AW         = $clog2(RAM_WORDS);
    localparam int DATA_BASE      = 'h200;                  // LDA/STA window above the code
    localparam int HALT_LIMIT     = MAX_INSTR * 16;         // At most 15 cycles per instruction
    localparam int PROGRAM_CYCLES = MAX_INSTR * 19 + 32;    // Load, reset, idle and run
    localparam int WATCHDOG_NS    = (NUM_PROGRAMS * PROGRAM_CYCLES + RAM_WORDS + 64) * CLK_PERIOD;

    logic  clk;
    logic  reset;
    logic  start;
    logic  prog_we;
    addr_t prog_addr;
    data_t prog_data;
    data_t out_data;
    logic  out_valid;
    logic  halted;
    int    mismatch_count;
    int    unexpected_count;
    int    checked_count;
    int    seed;
    data_t model_mem [RAM_WORDS];                           // Mirror of the DUT RAM
    data_t prog_bytes [$];
    int    control_errors;
    int    missing_errors;
    int    timeout_errors;

    cpu_top cpu_top_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .halted    (halted)
    );

    cpu_checker checker_inst (
        .clk              (clk),
        .reset            (reset),
        .out_valid        (out_valid),
        .out_data         (out_data),
        .halted           (halted),
        .mismatch_count   (mismatch_count),
        .unexpected_count (unexpected_count),
        .checked_count    (checked_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t before all programs finished", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    // ========================================================================
    // Random program generation
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic bit is_known(input data_t op);
        case (op)
            NOP, HLT, LDI_A, LDA, STA, ADI, SBI, OUT, JMP, JZ, JC, JN: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int operand_count(input data_t op);
        case (op)
            LDI_A, ADI, SBI:           return 1;        // Immediate byte
            LDA, STA, JMP, JZ, JC, JN: return 2;        // lo, hi
            default:                   return 0;
        endcase
    endfunction

    function automatic data_t random_opcode();
        case (rand_below(16))
            0:         return NOP;
            1, 2:      return LDI_A;
            3:         return LDA;
            4:         return STA;
            5, 6:      return ADI;
            7, 8:      return SBI;
            9, 10, 11: return OUT;
            12:        return JMP;
            13:        return JZ;
            14:        return JC;
            default:   return JN;
        endcase
    endfunction

    function automatic data_t unknown_opcode();
        data_t op;
        op = data_t'(rand_below(256));
        while (is_known(op))
            op = data_t'(rand_below(256));
        return op;
    endfunction

    task automatic push_address(input int low_addr);
        addr_t addr;
        // Random alias bits above the decoded RAM range
        addr = addr_t'((rand_below(1 << (`CPU_ADDR_WIDTH - RAM_AW)) << RAM_AW) | low_addr);
        prog_bytes.push_back(addr[7:0]);
        prog_bytes.push_back(addr[15:8]);
    endtask

    task automatic build_program();
        data_t ops [MAX_INSTR];
        int    starts [MAX_INSTR + 1];                      // Byte offset of each instruction
        int    n_instr;
        int    bad_slot;
        n_instr   = MIN_INSTR + rand_below(MAX_INSTR - MIN_INSTR + 1);
        bad_slot  = (rand_below(4) == 0) ? 1 + rand_below(n_instr - 2) : -1;
        starts[0] = 0;
        for (int i = 0; i < n_instr; i++) begin
            if (i == 0)                ops[i] = LDI_A;      // A has no reset value
            else if (i == n_instr - 1) ops[i] = HLT;
            else if (i == bad_slot)    ops[i] = unknown_opcode();
            else                       ops[i] = random_opcode();
            starts[i + 1] = starts[i] + 1 + operand_count(ops[i]);
        end
        prog_bytes.delete();
        for (int i = 0; i < n_instr; i++) begin
            prog_bytes.push_back(ops[i]);
            case (ops[i])
                LDI_A, ADI, SBI: prog_bytes.push_back(data_t'(rand_below(256)));
                LDA, STA:        push_address(DATA_BASE + rand_below(32));  // Small window
                JMP, JZ, JC, JN: push_address(starts[i + 1 + rand_below(n_instr - 1 - i)]);
                default: ;
            endcase
        end
    endtask

    // ========================================================================
    // ISA model that fills the checker queue with the expected OUT bytes
    task automatic run_model();
        addr_t      pc;
        data_t      a;
        data_t      op;
        data_t      lo;
        data_t      hi;
        logic       z;
        logic       c;
        logic       n;
        logic [8:0] wide;                                   // Carry or borrow on top
        int         steps;
        bit         running;
        pc      = `CPU_ORIGIN;
        a       = '0;
        z       = 1'b0;
        c       = 1'b0;
        n       = 1'b0;
        steps   = 0;
        running = 1'b1;
        while (running && steps < MAX_INSTR * 2) begin
            op = model_mem[int'(pc) % RAM_WORDS];
            lo = model_mem[(int'(pc) + 1) % RAM_WORDS];
            hi = model_mem[(int'(pc) + 2) % RAM_WORDS];
            pc = pc + addr_t'(1 + operand_count(op));
            steps++;
            case (op)
                NOP: ;
                HLT: running = 1'b0;
                LDI_A, LDA: begin
                    a = (op == LDI_A) ? lo : model_mem[int'({hi, lo}) % RAM_WORDS];
                    z = (a == '0);
                    n = a[`CPU_DATA_WIDTH-1];
                    c = 1'b0;                               // Loads clear carry
                end
                STA: model_mem[int'({hi, lo}) % RAM_WORDS] = a;
                ADI, SBI: begin
                    wide = (op == ADI) ? {1'b0, a} + {1'b0, lo} : {1'b0, a} - {1'b0, lo};
                    a    = wide[7:0];
                    c    = wide[8];
                    z    = (a == '0);
                    n    = a[`CPU_DATA_WIDTH-1];
                end
                OUT: checker_inst.push_expected(a);
                JMP: pc = {hi, lo};
                JZ:  if (z) pc = {hi, lo};
                JC:  if (c) pc = {hi, lo};
                JN:  if (n) pc = {hi, lo};
                default: running = 1'b0;                    // Unknown opcode halts
            endcase
        end
    endtask

    // ========================================================================
    // Stimulus driven on the falling edge
    task automatic write_ram(input int addr, input data_t value);
        @(negedge clk);
        prog_we         = 1'b1;
        prog_addr       = addr_t'(addr);
        prog_data       = value;
        model_mem[addr] = value;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (out_valid || halted) begin
                $display("out_valid or halted went high at %0t before start", $time);
                control_errors++;
            end
        end
    endtask

    task automatic wait_for_halt(input int prog_index);
        int cycles;
        int pending;
        cycles = 0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Program %0d did not halt within %0d cycles", prog_index, HALT_LIMIT);
            timeout_errors++;
        end else begin
            repeat (4) @(negedge clk);                      // Any stray output shows up here
            if (!halted) begin
                $display("Program %0d: halted fell at %0t without reset", prog_index, $time);
                control_errors++;
            end
        end
        pending = checker_inst.pending_count();
        if (pending != 0) begin
            $display("Program %0d ended with %0d expected outputs never seen",
                     prog_index, pending);
            missing_errors += pending;
        end
        checker_inst.flush_expected();
    endtask

    // ========================================================================
    // Main sequence
    initial begin
        seed           = 32'h5bec;
        reset          = 1'b1;                              // Held through the RAM preload
        start          = 1'b0;
        prog_we        = 1'b0;
        prog_addr      = '0;
        prog_data      = '0;
        control_errors = 0;
        missing_errors = 0;
        timeout_errors = 0;
        for (int i = 0; i < RAM_WORDS; i++)
            write_ram(i, data_t'(rand_below(256)));
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            build_program();
            foreach (prog_bytes[i])
                write_ram(i, prog_bytes[i]);
            @(negedge clk);
            prog_we = 1'b0;
            apply_reset();
            check_idle(2 + rand_below(4));
            run_model();
            @(negedge clk);
            start = 1'b1;                                   // One-cycle pulse
            @(negedge clk);
            start = 1'b0;
            wait_for_halt(p);
        end
        @(negedge clk);
        $display("Checked %0d: %0d wrong, %0d extra, %0d missing, %0d control, %0d timeouts",
                 checked_count, mismatch_count, unexpected_count, missing_errors,
                 control_errors, timeout_errors);
        if (mismatch_count + unexpected_count + missing_errors + control_errors
            + timeout_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
